//--- bench/fetch_mem_checker.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_checker import core_if_pkg::*; (
    input  logic        clk, rst, op_valid, branch_taken, mem_read, mem_write,
    input  logic [31:0] pc, imm, mem_address, store_data,
    input  logic        op_ready, freeze, instr_valid, load_valid,
    input  logic [31:0] instruction_out, load_data,
    input  logic        bus_req, bus_write, bus_ack,
    input  logic [31:0] bus_address, bus_wdata,
    output int          error_count, accepted_count, instr_count
);

    localparam int OP_TIMEOUT = 300; // Cycles from acceptance to instr_valid.

    logic [31:0] store_map [logic [31:0]];
    logic [64:0] bus_q [$]; // {write, address, store data} in bus order.
    logic [31:0] load_q [$];
    logic [31:0] instr_q [$];
    logic        pending;
    int          wait_cycles;

    function automatic logic [31:0] expected_word(logic [31:0] addr, bit is_fetch);
        if (is_fetch && (addr[5:2] == 4'hF)) begin
            return BAD_FETCH;
        end
        if (store_map.exists(addr)) begin
            return store_map[addr];
        end
        return addr ^ 32'h5A5A0000;
    endfunction

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_problem(string what);
        $display("Error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic take_op();
        logic [31:0] fetch_addr;
        logic [31:0] word;
        if (pending) begin
            report_problem("operation accepted while another was outstanding");
        end
        if (mem_write) begin
            bus_q.push_back({1'b1, mem_address, store_data});
            store_map[mem_address] = store_data;
        end else if (mem_read) begin
            bus_q.push_back({1'b0, mem_address, 32'h0});
            load_q.push_back(expected_word(mem_address, 1'b0));
        end
        fetch_addr = branch_taken ? pc + imm - 32'd4 : pc;
        word = expected_word(fetch_addr, 1'b1);
        bus_q.push_back({1'b0, fetch_addr, 32'h0});
        instr_q.push_back((word == BAD_FETCH) ? BUBBLE_INSTR : word);
        accepted_count++;
        pending     = 1'b1;
        wait_cycles = 0;
    endtask

    task automatic check_bus();
        logic [64:0] exp;
        if (bus_q.size() == 0) begin
            report_problem("bus transaction when none was expected");
        end else begin
            exp = bus_q.pop_front();
            compare_value("bus_address", exp[63:32], bus_address);
            compare_value("bus_write", 32'(exp[64]), 32'(bus_write));
            if (exp[64]) begin
                compare_value("bus_wdata", exp[31:0], bus_wdata);
            end
        end
    endtask

    // All inputs change away from the rising edge, so the values seen here are settled.
    always @(posedge clk) begin
        if (rst) begin
            error_count    = 0;
            accepted_count = 0;
            instr_count    = 0;
            pending        = 1'b0;
            bus_q.delete();
            load_q.delete();
            instr_q.delete();
        end else begin
            if (accepted_count == 0 && (freeze || instr_valid || load_valid || bus_req)) begin
                report_problem("freeze, instr_valid, load_valid or bus_req high before any operation");
            end
            if (instr_valid) begin
                instr_count++;
                if (!pending || instr_q.size() == 0) begin
                    report_problem("instr_valid with no operation outstanding");
                end else begin
                    compare_value("instruction_out", instr_q.pop_front(), instruction_out);
                end
                if (load_q.size() != 0 || bus_q.size() != 0) begin
                    report_problem("instr_valid before the data access of the operation ended");
                end
                pending = 1'b0;
            end
            if (load_valid) begin
                if (load_q.size() == 0) begin
                    report_problem("load_valid with no load outstanding");
                end else begin
                    compare_value("load_data", load_q.pop_front(), load_data);
                end
            end
            if (bus_req && bus_ack) begin
                check_bus();
            end
            // The core stays frozen from the cycle after acceptance until instr_valid.
            compare_value("freeze", 32'(pending), 32'(freeze));
            compare_value("op_ready", 32'(!pending), 32'(op_ready));
            if (op_valid && op_ready) begin
                take_op();
            end
            if (pending) begin
                wait_cycles++;
                if (wait_cycles > OP_TIMEOUT) begin
                    report_problem("timed out waiting for instr_valid");
                    pending = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/fetch_mem_props.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_props #(
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic not_empty,
    input logic credit_return
);

    int level; // Occupancy rebuilt from the handshake alone.
    int full_fails = 0;
    int empty_fails = 0;
    int credit_fails = 0;
    int fail_count;

    assign fail_count = full_fails + empty_fails + credit_fails;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            level <= 0;
        end else begin
            level <= level + int'(push && (level < DEPTH)) - int'(pop && (level > 0));
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> level < DEPTH)
        else begin
            $error("push arrived while the queue was full");
            full_fails++;
        end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty)
        else begin
            $error("pop happened while the queue was empty");
            empty_fails++;
        end

    credit_with_pop: assert property (@(posedge clk) disable iff (rst) credit_return == pop)
        else begin
            $error("credit_return did not coincide with pop");
            credit_fails++;
        end

endmodule

bind credit_fifo fetch_mem_props #(.DEPTH(DEPTH)) u_props (
    .clk(clk), .rst(rst), .push(push), .pop(pop), .not_empty(not_empty),
    .credit_return(credit_return)
);

`default_nettype wire

//--- bench/fetch_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_tb import core_if_pkg::*; ();

    localparam int NUM_OPS       = 100;
    localparam int READY_TIMEOUT = 200; // Well above the slowest load plus fetch.

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        op_valid, branch_taken, mem_read, mem_write;
    logic [31:0] pc, imm, mem_address, store_data;
    logic        op_ready, freeze, instr_valid, load_valid;
    logic [31:0] instruction_out, load_data;
    logic        bus_req, bus_write;
    logic        bus_ack = 1'b0;
    logic [31:0] bus_address, bus_wdata;
    logic [31:0] bus_rdata = '0;
    int          error_count, accepted_count, instr_count;
    int          bench_errors = 0;
    int          assert_fails;
    int          ack_wait = 0;
    logic [31:0] mem_model [logic [31:0]];

    always #20 clk = ~clk;

    fetch_mem_top #(.REQ_DEPTH(4), .RESP_DEPTH(2)) DUT (.*);

    fetch_mem_checker CHK (.*);

    function automatic logic [31:0] model_read(logic [31:0] addr);
        if (addr[5:2] == 4'hF) begin
            return BAD_FETCH; // Data addresses avoid this slot, so only fetches land here.
        end
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return addr ^ 32'h5A5A0000;
    endfunction

    function automatic logic [31:0] data_addr();
        logic [31:0] addr;
        addr = 32'h0000_1000 | ($urandom() & 32'h0000_007C);
        if (addr[5:2] == 4'hF) begin
            addr[2] = 1'b0;
        end
        return addr;
    endfunction

    // Bus memory, answering 1 to 6 cycles after bus_req rises.
    always @(negedge clk) begin
        if (bus_ack) begin
            bus_ack  = 1'b0;
            ack_wait = $urandom_range(5, 0);
        end else if (!rst && bus_req) begin
            if (ack_wait == 0) begin
                if (bus_write) begin
                    mem_model[bus_address] = bus_wdata;
                end
                bus_rdata = bus_write ? 32'h0 : model_read(bus_address);
                bus_ack   = 1'b1;
            end else begin
                ack_wait--;
            end
        end
    end

    task automatic wait_ready(output bit ok);
        int waited;
        waited = 0;
        while (!op_ready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = op_ready;
        if (!ok) begin
            $display("Timed out after %0d cycles waiting for op_ready", waited);
            bench_errors++;
        end
    endtask

    initial begin
        bit ok;
        int kind;
        void'($urandom(32'hea56487d));
        op_valid     = 1'b0;
        pc           = '0;
        branch_taken = 1'b0;
        imm          = '0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_address  = '0;
        store_data   = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        ok = 1'b1;
        for (int i = 0; i < NUM_OPS && ok; i++) begin
            kind         = $urandom_range(3, 0);
            op_valid     = 1'b1;
            pc           = $urandom() & 32'h0000_03FC;
            branch_taken = ($urandom_range(2, 0) == 0);
            imm          = $urandom() & 32'h0000_01FC;
            mem_read     = (kind == 1);
            mem_write    = (kind == 2);
            mem_address  = data_addr();
            store_data   = $urandom();
            wait_ready(ok);
            @(negedge clk); // Taken on the rising edge just passed.
            op_valid = 1'b0;
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
        if (ok) begin
            wait_ready(ok);
        end
        repeat (4) @(negedge clk);
        if (ok && (accepted_count != NUM_OPS || instr_count != NUM_OPS)) begin
            $display("Operations lost: %0d sent, %0d accepted, %0d instructions returned",
                     NUM_OPS, accepted_count, instr_count);
            bench_errors++;
        end
        assert_fails = DUT.u_req_fifo.u_props.fail_count + DUT.u_resp_fifo.u_props.fail_count;
        $display("Error counts: checker %0d, bench %0d, assertions %0d",
                 error_count, bench_errors, assert_fails);
        if (error_count + bench_errors + assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/mem_req_pkg.sv
verilog/core_if_pkg.sv
verilog/credit_fifo.sv
verilog/request_unit.sv
verilog/mem_port.sv
verilog/fetch_mem_top.sv
bench/fetch_mem_props.sv
bench/fetch_mem_checker.sv
bench/fetch_mem_tb.sv

//--- verilog/core_if_pkg.sv
`default_nettype none

package core_if_pkg;

    // Word returned by memory when the fetch could not be served.
    localparam logic [31:0] BAD_FETCH = 32'hBAD1BAD1;

    // Sent to the core in place of a bad fetch.
    localparam logic [31:0] BUBBLE_INSTR = 32'h0000_0000;

endpackage

`default_nettype wire

//--- verilog/credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     not_empty,
    output payload_t pop_data,
    output logic     credit_return
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign not_empty     = (count != '0);
    assign do_push       = push && (count != CW'(DEPTH)); // The producer's credits keep this true.
    assign do_pop        = pop && not_empty;
    assign credit_return = do_pop; // One credit back per entry freed.
    assign pop_data      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_top import mem_req_pkg::*; #(
    parameter int REQ_DEPTH  = 4,
    parameter int RESP_DEPTH = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              op_valid,
    input  logic [ADDR_W-1:0] pc,
    input  logic              branch_taken,
    input  logic [ADDR_W-1:0] imm,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [ADDR_W-1:0] mem_address,
    input  logic [ADDR_W-1:0] store_data,
    output logic              op_ready,
    output logic              freeze,
    output logic [ADDR_W-1:0] instruction_out,
    output logic              instr_valid,
    output logic [ADDR_W-1:0] load_data,
    output logic              load_valid,
    output logic              bus_req,
    output logic              bus_write,
    output logic [ADDR_W-1:0] bus_address,
    output logic [ADDR_W-1:0] bus_wdata,
    input  logic              bus_ack,
    input  logic [ADDR_W-1:0] bus_rdata
);

    logic      req_push;
    mem_req_t  req_push_data;
    logic      req_not_empty;
    mem_req_t  req_pop_data;
    logic      req_pop;
    logic      req_credit;
    logic      resp_push;
    mem_resp_t resp_push_data;
    logic      resp_not_empty;
    mem_resp_t resp_pop_data;
    logic      resp_pop;
    logic      resp_credit;

    request_unit #(.REQ_CREDITS(REQ_DEPTH)) u_request_unit (
        .clk(clk), .rst(rst), .op_valid(op_valid), .pc(pc),
        .branch_taken(branch_taken), .imm(imm), .mem_read(mem_read),
        .mem_write(mem_write), .mem_address(mem_address), .store_data(store_data),
        .op_ready(op_ready), .freeze(freeze), .instruction_out(instruction_out),
        .instr_valid(instr_valid), .load_data(load_data), .load_valid(load_valid),
        .req_push(req_push), .req_data(req_push_data), .req_credit(req_credit),
        .resp_not_empty(resp_not_empty), .resp_data(resp_pop_data), .resp_pop(resp_pop)
    );

    credit_fifo #(.DEPTH(REQ_DEPTH), .payload_t(mem_req_t)) u_req_fifo (
        .clk(clk), .rst(rst), .push(req_push), .push_data(req_push_data),
        .pop(req_pop), .not_empty(req_not_empty), .pop_data(req_pop_data),
        .credit_return(req_credit)
    );

    credit_fifo #(.DEPTH(RESP_DEPTH), .payload_t(mem_resp_t)) u_resp_fifo (
        .clk(clk), .rst(rst), .push(resp_push), .push_data(resp_push_data),
        .pop(resp_pop), .not_empty(resp_not_empty), .pop_data(resp_pop_data),
        .credit_return(resp_credit)
    );

    mem_port #(.RESP_CREDITS(RESP_DEPTH)) u_mem_port (
        .clk(clk), .rst(rst), .req_not_empty(req_not_empty), .req_data(req_pop_data),
        .req_pop(req_pop), .resp_push(resp_push), .resp_data(resp_push_data),
        .resp_credit(resp_credit), .bus_req(bus_req), .bus_write(bus_write),
        .bus_address(bus_address), .bus_wdata(bus_wdata), .bus_ack(bus_ack),
        .bus_rdata(bus_rdata)
    );

endmodule

`default_nettype wire

//--- verilog/mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module mem_port import mem_req_pkg::*; #(
    parameter int RESP_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_not_empty,
    input  mem_req_t          req_data,
    output logic              req_pop,
    output logic              resp_push,
    output mem_resp_t         resp_data,
    input  logic              resp_credit,
    output logic              bus_req,
    output logic              bus_write,
    output logic [ADDR_W-1:0] bus_address,
    output logic [ADDR_W-1:0] bus_wdata,
    input  logic              bus_ack,
    input  logic [ADDR_W-1:0] bus_rdata
);

    localparam int CW = $clog2(RESP_CREDITS + 1);

    typedef enum logic [1:0] {pt_idle, pt_bus, pt_resp} port_state_t;

    port_state_t       state;
    logic [CW-1:0]     credits;
    access_kind_t      cur_kind;
    logic [ADDR_W-1:0] cur_addr;
    logic [ADDR_W-1:0] cur_wdata;
    logic [ADDR_W-1:0] rdata_q;

    // A request is only taken when its response has somewhere to go.
    assign req_pop     = (state == pt_idle) && req_not_empty && (credits != '0);
    assign bus_req     = (state == pt_bus);
    assign bus_write   = bus_req && (cur_kind == kind_store);
    assign bus_address = cur_addr;
    assign bus_wdata   = cur_wdata;
    assign resp_push   = (state == pt_resp);
    assign resp_data   = '{kind: cur_kind, rdata: rdata_q};

    always_ff @(posedge clk) begin
        if (req_pop) begin
            cur_kind  <= req_data.kind;
            cur_addr  <= req_data.addr;
            cur_wdata <= req_data.wdata;
        end
        if (bus_req && bus_ack) begin
            rdata_q <= (cur_kind == kind_store) ? '0 : bus_rdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= pt_idle;
            credits <= CW'(RESP_CREDITS);
        end else begin
            credits <= credits - CW'(resp_push) + CW'(resp_credit);
            case (state)
                pt_idle: begin
                    if (req_pop) begin
                        state <= pt_bus;
                    end
                end
                pt_bus: begin
                    if (bus_ack) begin
                        state <= pt_resp;
                    end
                end
                pt_resp: state <= pt_idle; // Push lasts exactly one cycle.
                default: state <= pt_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_req_pkg.sv
`default_nettype none

package mem_req_pkg;

    localparam int ADDR_W = 32; // Address and data word width.

    typedef enum logic [1:0] {
        kind_fetch = 2'd0,
        kind_load  = 2'd1,
        kind_store = 2'd2
    } access_kind_t;

    // Request as it travels from the request unit to the memory port.
    typedef struct packed {
        access_kind_t      kind;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] wdata; // Only meaningful for stores.
    } mem_req_t;

    // Response as it travels back to the request unit.
    typedef struct packed {
        access_kind_t      kind;
        logic [ADDR_W-1:0] rdata; // Zero for stores.
    } mem_resp_t;

endpackage

`default_nettype wire

//--- verilog/request_unit.sv
`timescale 1ns/10ps
`default_nettype none

module request_unit import mem_req_pkg::*, core_if_pkg::*; #(
    parameter int REQ_CREDITS = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              op_valid,
    input  logic [ADDR_W-1:0] pc,
    input  logic              branch_taken,
    input  logic [ADDR_W-1:0] imm,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [ADDR_W-1:0] mem_address,
    input  logic [ADDR_W-1:0] store_data,
    output logic              op_ready,
    output logic              freeze,
    output logic [ADDR_W-1:0] instruction_out,
    output logic              instr_valid,
    output logic [ADDR_W-1:0] load_data,
    output logic              load_valid,
    output logic              req_push,
    output mem_req_t          req_data,
    input  logic              req_credit,
    input  logic              resp_not_empty,
    input  mem_resp_t         resp_data,
    output logic              resp_pop
);

    localparam int CW = $clog2(REQ_CREDITS + 1);

    typedef enum logic [1:0] {st_idle, st_data, st_fetch, st_wait} issue_state_t;

    issue_state_t      state;
    logic [CW-1:0]     credits;
    logic [ADDR_W-1:0] fetch_addr;
    access_kind_t      data_kind;
    logic [ADDR_W-1:0] data_addr;
    logic [ADDR_W-1:0] data_wdata;
    logic [ADDR_W-1:0] latched_instr;
    logic              bubble;
    logic              accept;
    logic              fetch_done;

    assign freeze     = (state != st_idle); // Held from the cycle after acceptance to the fetch return.
    assign op_ready   = !freeze;
    assign accept     = op_valid && op_ready;
    assign req_push   = ((state == st_data) || (state == st_fetch)) && (credits != '0);
    assign resp_pop   = resp_not_empty; // Responses are always taken at once.
    assign fetch_done = resp_pop && (resp_data.kind == kind_fetch);

    assign instruction_out = bubble ? BUBBLE_INSTR : latched_instr;

    always_comb begin
        if (state == st_data) begin
            req_data = '{kind: data_kind, addr: data_addr, wdata: data_wdata};
        end else begin
            req_data = '{kind: kind_fetch, addr: fetch_addr, wdata: '0};
        end
    end

    // The data access always goes ahead of the fetch.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= (mem_read || mem_write) ? st_data : st_fetch;
                    end
                end
                st_data: begin
                    if (req_push) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (req_push) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (fetch_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_addr <= branch_taken ? pc + imm - 32'd4 : pc; // Taken branch target.
            data_kind  <= mem_write ? kind_store : kind_load;
            data_addr  <= mem_address;
            data_wdata <= store_data;
        end
        if (fetch_done && (resp_data.rdata != BAD_FETCH)) begin
            latched_instr <= resp_data.rdata;
        end
        if (resp_pop && (resp_data.kind == kind_load)) begin
            load_data <= resp_data.rdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits     <= CW'(REQ_CREDITS);
            instr_valid <= 1'b0;
            load_valid  <= 1'b0;
            bubble      <= 1'b1; // Output reads as zero until the first good fetch.
        end else begin
            credits     <= credits - CW'(req_push) + CW'(req_credit);
            instr_valid <= fetch_done;
            load_valid  <= resp_pop && (resp_data.kind == kind_load);
            if (fetch_done) begin
                bubble <= (resp_data.rdata == BAD_FETCH);
            end
        end
    end

endmodule

`default_nettype wire
